// ==== logic/thorDecodePkg.sv ====
package thorDecodePkg;

	// ========================================================================
	// Opcodes
	// ========================================================================

	// The opcode sits in the low seven bits of every format
	// BRA is only seen on the branch side of the fetch sequencer
	typedef enum logic [6:0] {
		R2     = 7'h02,
		R3     = 7'h03,
		ADD2R  = 7'h04,
		SUB2R  = 7'h05,
		AND2R  = 7'h08,
		OR2R   = 7'h09,
		XOR2R  = 7'h0A,
		CMP2R  = 7'h0B,
		SLT2R  = 7'h0C,
		ADDI   = 7'h14,
		ANDI   = 7'h18,
		ORI    = 7'h19,
		BRA    = 7'h20,
		LDBX   = 7'h60,
		LDWX   = 7'h61,
		LDTX   = 7'h62,
		LDOX   = 7'h63,
		STBX   = 7'h70,
		STWX   = 7'h71,
		STTX   = 7'h72,
		STOX   = 7'h73,
		NOP    = 7'h7F
	} opcode_e;

	// ========================================================================
	// Instruction formats
	// ========================================================================

	// Generic view, Rt is the target except for stores where it is the source
	typedef struct packed {
		logic [18:0] raw;
		logic        v;
		logic [4:0]  rt;
		opcode_e     opcode;
	} anyFmt_t;

	// Three register form carries the mask in bits 18..16
	typedef struct packed {
		logic [12:0] upper;
		logic [2:0]  rvm;
		logic [8:0]  lower;
		opcode_e     opcode;
	} r3Fmt_t;

	// Long immediate with vector flag, mask in bits 15..13
	typedef struct packed {
		logic [15:0] upper;
		logic [2:0]  rvm;
		logic [5:0]  lower;
		opcode_e     opcode;
	} rilvFmt_t;

	// Indexed load, mask high up in bits 28..26
	typedef struct packed {
		logic [2:0]  upper;
		logic [2:0]  rvm;
		logic [18:0] lower;
		opcode_e     opcode;
	} ldxFmt_t;

	// Indexed store, mask in bits 10..8 overlapping the source register field
	typedef struct packed {
		logic [20:0] upper;
		logic [2:0]  rvm;
		logic        lower;
		opcode_e     opcode;
	} stxFmt_t;

	typedef union packed {
		anyFmt_t  any;
		r3Fmt_t   r3;
		rilvFmt_t rilv;
		ldxFmt_t  ldx;
		stxFmt_t  stx;
	} Instruction;

	// ========================================================================
	// Pipeline records
	// ========================================================================

	typedef struct packed {
		logic isReg;
		logic isRil;
		logic isLoadX;
		logic isStoreX;
	} classFlags_t;

	// One queue slot, the word with the pc it was fetched at
	typedef struct packed {
		logic [31:0] pc;
		Instruction  ir;
	} queueEntry_t;

	typedef struct packed {
		logic [31:0] pc;
		opcode_e     opcode;
		classFlags_t flags;
		logic [4:0]  rt;
		logic [2:0]  rvm;
	} decoded_t;

endpackage

// ==== logic/thorFetchSequencer.sv ====
`timescale 1ns/1ps

module thorFetchSequencer #(
	parameter logic [31:0] ResetPc = 32'hFFFC0000
) (
	input  logic                        clk,
	input  logic                        arstN,
	input  logic                        instrValid,
	input  thorDecodePkg::Instruction   instrWord,
	input  logic                        branchValid,
	input  logic [31:0]                 branchTarget,
	input  logic                        full,
	output logic                        pushValid,
	output thorDecodePkg::queueEntry_t  pushEntry,
	output logic                        overflow
);

	// Program counter of the next word to arrive
	logic [31:0] pc;
	// Pc given to a word strobed this cycle
	logic [31:0] tagPc;

	// A branch in the same cycle as a word retargets that word as well
	always_comb begin
		tagPc = branchValid ? branchTarget : pc;
	end

	// ========================================================================
	// Program counter
	// ========================================================================

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			pc <= ResetPc;
		end else if (instrValid) begin
			// Step past the word just taken
			pc <= tagPc + 32'd4;
		end else if (branchValid) begin
			pc <= branchTarget;
		end
	end

	// ========================================================================
	// Push register towards the queue
	// ========================================================================

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			pushValid <= 1'b0;
		end else begin
			pushValid <= instrValid;
		end
	end

	// The tagged word only loads when a word actually arrives
	always_ff @(posedge clk) begin
		if (instrValid) begin
			pushEntry.pc <= tagPc;
			pushEntry.ir <= instrWord;
		end
	end

	// A push into a full queue is lost, flag it until the next reset
	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			overflow <= 1'b0;
		end else if (pushValid && full) begin
			overflow <= 1'b1;
		end
	end

endmodule

// ==== logic/thorInstrQueue.sv ====
`timescale 1ns/1ps

module thorInstrQueue #(
	parameter int QueueDepth = 8
) (
	input  logic                        clk,
	input  logic                        arstN,
	input  logic                        push,
	input  thorDecodePkg::queueEntry_t  pushEntry,
	input  logic                        pop,
	output thorDecodePkg::queueEntry_t  headEntry,
	output logic                        full,
	output logic                        empty
);

	import thorDecodePkg::*;

	// Index width, QueueDepth is a power of two of at least two
	localparam int IdxW = $clog2(QueueDepth);
	// Pointer increment sized to the pointers
	localparam logic [IdxW:0] PtrOne = 1;

	// ========================================================================
	// Storage
	// ========================================================================

	queueEntry_t mem [0:QueueDepth-1];

	// Pointers carry one extra wrap bit above the index
	logic [IdxW:0] wrPtr;
	logic [IdxW:0] rdPtr;
	logic          wrEn;

	// A push meeting a full queue is dropped even if a pop frees a slot
	assign wrEn = push && !full;

	always_ff @(posedge clk) begin
		if (wrEn) begin
			mem[wrPtr[IdxW-1:0]] <= pushEntry;
		end
	end

	// ========================================================================
	// Pointers
	// ========================================================================

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			wrPtr <= '0;
		end else if (wrEn) begin
			wrPtr <= wrPtr + PtrOne;
		end
	end

	// The stage only pops when the queue holds something
	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			rdPtr <= '0;
		end else if (pop) begin
			rdPtr <= rdPtr + PtrOne;
		end
	end

	// ========================================================================
	// Status and head
	// ========================================================================

	// Same index with differing wrap bits means every slot is taken
	assign full  = (wrPtr[IdxW] != rdPtr[IdxW])
		&& (wrPtr[IdxW-1:0] == rdPtr[IdxW-1:0]);
	assign empty = (wrPtr == rdPtr);

	// Head is shown straight from the array so the stage can decode it
	// in the same cycle it pops
	assign headEntry = mem[rdPtr[IdxW-1:0]];

endmodule

// ==== logic/thorDecodeClass.sv ====
`timescale 1ns/1ps

module thorDecodeClass (
	input  thorDecodePkg::Instruction   ir,
	output thorDecodePkg::classFlags_t  flags
);

	import thorDecodePkg::*;

	// ========================================================================
	// Opcode groups
	// ========================================================================

	// Only the opcode matters here, every format keeps it in the same place
	always_comb begin
		flags = '0;
		case (ir.any.opcode)
			// Register forms, both the generic ones and the two register ALU ops
			R2, R3,
			ADD2R, SUB2R, AND2R, OR2R, XOR2R, CMP2R, SLT2R: begin
				flags.isReg = 1'b1;
			end
			// Register with long immediate
			ADDI, ANDI, ORI: begin
				flags.isRil = 1'b1;
			end
			// Indexed loads of all four sizes
			LDBX, LDWX, LDTX, LDOX: begin
				flags.isLoadX = 1'b1;
			end
			// Indexed stores of all four sizes
			STBX, STWX, STTX, STOX: begin
				flags.isStoreX = 1'b1;
			end
			default: begin
				flags = '0;
			end
		endcase
	end

endmodule

// ==== logic/thorDecodeRvm.sv ====
`timescale 1ns/1ps

module thorDecodeRvm (
	input  thorDecodePkg::Instruction   ir,
	input  thorDecodePkg::classFlags_t  flags,
	output logic [2:0]                  rvm
);

	import thorDecodePkg::*;

	// Set for the two generic register forms within the register group
	logic isGenericReg;

	assign isGenericReg = (ir.any.opcode == R2) || (ir.any.opcode == R3);

	// ========================================================================
	// Mask field select
	// ========================================================================

	// The mask register moves around the word with the format, so each
	// group reads it through its own view of the word
	always_comb begin
		if (flags.isReg) begin
			if (isGenericReg) begin
				rvm = ir.r3.rvm;
			end else begin
				// Two register ALU ops keep it in the top three bits
				rvm = ir.any[31:29];
			end
		end else if (flags.isRil && ir.any.v) begin
			// Long immediates only carry a mask when the vector flag is set
			rvm = ir.rilv.rvm;
		end else if (flags.isLoadX) begin
			rvm = ir.ldx.rvm;
		end else if (flags.isStoreX) begin
			rvm = ir.stx.rvm;
		end else begin
			// No mask, element zero selects all lanes
			rvm = 3'd0;
		end
	end

endmodule

// ==== logic/thorDecodeStage.sv ====
`timescale 1ns/1ps

module thorDecodeStage (
	input  logic                        clk,
	input  logic                        arstN,
	input  thorDecodePkg::queueEntry_t  headEntry,
	input  logic                        empty,
	input  logic                        hold,
	output logic                        pop,
	output logic                        decValid,
	output thorDecodePkg::decoded_t     decOut
);

	import thorDecodePkg::*;

	// Class of the head word
	classFlags_t flags;
	// Mask register field of the head word
	logic [2:0]  rvm;
	// Target register, zero when the word writes nothing
	logic [4:0]  rt;
	// Record assembled from the head word before it is registered
	decoded_t    nextRec;

	// ========================================================================
	// Field decoders
	// ========================================================================

	thorDecodeClass uClass (
		.ir    (headEntry.ir),
		.flags (flags)
	);

	// The mask selector reuses the class flags from above
	thorDecodeRvm uRvm (
		.ir    (headEntry.ir),
		.flags (flags),
		.rvm   (rvm)
	);

	// Stores use the Rt slot for their source, NOP has no destination
	always_comb begin
		if (flags.isStoreX || (headEntry.ir.any.opcode == NOP)) begin
			rt = 5'd0;
		end else begin
			rt = headEntry.ir.any.rt;
		end
	end

	always_comb begin
		nextRec.pc     = headEntry.pc;
		nextRec.opcode = headEntry.ir.any.opcode;
		nextRec.flags  = flags;
		nextRec.rt     = rt;
		nextRec.rvm    = rvm;
	end

	// ========================================================================
	// Pop and output register
	// ========================================================================

	// Take the head whenever there is one and downstream is not stalled
	assign pop = !empty && !hold;

	// One pulse per popped word
	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			decValid <= 1'b0;
		end else begin
			decValid <= pop;
		end
	end

	// Record holds its last value between pops
	always_ff @(posedge clk) begin
		if (pop) begin
			decOut <= nextRec;
		end
	end

endmodule

// ==== logic/thorDecodeTop.sv ====
`timescale 1ns/1ps

module thorDecodeTop #(
	parameter int          QueueDepth = 8,
	parameter logic [31:0] ResetPc    = 32'hFFFC0000
) (
	input  logic                       clk,
	input  logic                       arstN,
	input  logic                       instrValid,
	input  thorDecodePkg::Instruction  instrWord,
	input  logic                       branchValid,
	input  logic [31:0]                branchTarget,
	input  logic                       hold,
	output logic                       decValid,
	output thorDecodePkg::decoded_t    decOut,
	output logic                       overflow
);

	import thorDecodePkg::*;

	// ========================================================================
	// Fetch to queue to decode
	// ========================================================================

	logic        pushValid;
	queueEntry_t pushEntry;
	logic        full;
	logic        empty;
	queueEntry_t headEntry;
	logic        pop;

	thorFetchSequencer #(
		.ResetPc (ResetPc)
	) uFetch (
		.clk          (clk),
		.arstN        (arstN),
		.instrValid   (instrValid),
		.instrWord    (instrWord),
		.branchValid  (branchValid),
		.branchTarget (branchTarget),
		.full         (full),
		.pushValid    (pushValid),
		.pushEntry    (pushEntry),
		.overflow     (overflow)
	);

	thorInstrQueue #(
		.QueueDepth (QueueDepth)
	) uQueue (
		.clk       (clk),
		.arstN     (arstN),
		.push      (pushValid),
		.pushEntry (pushEntry),
		.pop       (pop),
		.headEntry (headEntry),
		.full      (full),
		.empty     (empty)
	);

	thorDecodeStage uDecode (
		.clk       (clk),
		.arstN     (arstN),
		.headEntry (headEntry),
		.empty     (empty),
		.hold      (hold),
		.pop       (pop),
		.decValid  (decValid),
		.decOut    (decOut)
	);

endmodule

// ==== dv/thorDecodeTb.sv ====
`timescale 1ns/1ps

module thorDecodeTb;

	import thorDecodePkg::*;

	localparam int          QueueDepth    = 8;
	localparam logic [31:0] ResetPc       = 32'hFFFC0000;
	// Cycle budget of each test phase
	localparam int          ResetCycles   = 5;
	localparam int          LatencyCycles = 12;
	localparam int          RandomCycles  = 300;
	localparam int          HoldCycles    = 200;
	localparam int          FillCycles    = QueueDepth + 4;
	localparam int          DrainCycles   = QueueDepth + 40;
	localparam int          TailCycles    = 50;
	localparam int          StimCycles    = 3 * ResetCycles + LatencyCycles + RandomCycles
		+ HoldCycles + FillCycles + DrainCycles + TailCycles;
	localparam int          TimeoutCycles = 2 * StimCycles + 100;

	logic        clk;
	logic        arstN;
	logic        instrValid;
	Instruction  instrWord;
	logic        branchValid;
	logic [31:0] branchTarget;
	logic        hold;
	logic        decValid;
	decoded_t    decOut;
	logic        overflow;

	integer      seed;
	int          cycleCount;
	int          errorCount;
	opcode_e     opTable [22] = '{R2, R3, ADD2R, SUB2R, AND2R, OR2R, XOR2R, CMP2R,
		SLT2R, ADDI, ANDI, ORI, LDBX, LDWX, LDTX, LDOX, STBX, STWX, STTX, STOX, NOP, BRA};

	// Model state of the queue and of the push register in front of it
	queueEntry_t modelQ [$];
	logic        mPushValid;
	queueEntry_t mPushEntry;
	logic [31:0] mPc;
	logic        expValid;
	decoded_t    expRec;
	logic        expOverflow;

	thorDecodeTop #(
		.QueueDepth (QueueDepth),
		.ResetPc    (ResetPc)
	) u_dut (
		.clk          (clk),
		.arstN        (arstN),
		.instrValid   (instrValid),
		.instrWord    (instrWord),
		.branchValid  (branchValid),
		.branchTarget (branchTarget),
		.hold         (hold),
		.decValid     (decValid),
		.decOut       (decOut),
		.overflow     (overflow)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	// Watchdog on the whole run
	initial begin
		cycleCount = 0;
		forever begin
			@(posedge clk);
			cycleCount++;
			if (cycleCount > TimeoutCycles) begin
				failRun("Timeout, the run went past its cycle limit");
			end
		end
	end

	// ========================================================================
	// Failure reporting and compares
	// ========================================================================

	task automatic failRun(input string why);
		$display("%s", why);
		$display("Done: errors found");
		$fatal(1);
	endtask

	task automatic fieldError(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		errorCount++;
		$display("** Error: %s got %h expected %h", name, got, exp);
		failRun("Decoded record mismatch");
	endtask

	task automatic checkDecoded(input decoded_t got, input decoded_t exp);
		if (got.pc !== exp.pc) fieldError("decOut.pc", got.pc, exp.pc);
		if (got.opcode !== exp.opcode)
			fieldError("decOut.opcode", 32'(got.opcode), 32'(exp.opcode));
		if (got.flags !== exp.flags)
			fieldError("decOut.flags", 32'(got.flags), 32'(exp.flags));
		if (got.rt !== exp.rt) fieldError("decOut.rt", 32'(got.rt), 32'(exp.rt));
		if (got.rvm !== exp.rvm) fieldError("decOut.rvm", 32'(got.rvm), 32'(exp.rvm));
	endtask

	task automatic checkLevel(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			errorCount++;
			$display("** Error: %s got %h expected %h", name, got, exp);
			failRun("Level mismatch");
		end
	endtask

	task automatic checkOutputs();
		checkLevel("decValid", decValid, expValid);
		if (expValid) begin
			checkDecoded(decOut, expRec);
		end
		checkLevel("overflow", overflow, expOverflow);
	endtask

	// ========================================================================
	// Reference model
	// ========================================================================

	// Record of one word worked out from the format rules on the raw bits
	function automatic decoded_t refDecode(input logic [31:0] pc, input logic [31:0] w);
		opcode_e  op;
		decoded_t d;
		logic     twoReg;
		op = opcode_e'(w[6:0]);
		twoReg = op inside {ADD2R, SUB2R, AND2R, OR2R, XOR2R, CMP2R, SLT2R};
		d.pc = pc;
		d.opcode = op;
		d.flags.isReg = twoReg || (op == R2) || (op == R3);
		d.flags.isRil = op inside {ADDI, ANDI, ORI};
		d.flags.isLoadX = op inside {LDBX, LDWX, LDTX, LDOX};
		d.flags.isStoreX = op inside {STBX, STWX, STTX, STOX};
		d.rt = (d.flags.isStoreX || op == NOP) ? 5'd0 : w[11:7];
		if (op == R2 || op == R3) d.rvm = w[18:16];
		else if (twoReg) d.rvm = w[31:29];
		else if (d.flags.isRil && w[12]) d.rvm = w[15:13];
		else if (d.flags.isLoadX) d.rvm = w[28:26];
		else if (d.flags.isStoreX) d.rvm = w[10:8];
		else d.rvm = 3'd0;
		return d;
	endfunction

	// One clock edge of the model driven by the inputs seen at that edge
	task automatic advanceModel(input logic iv, input Instruction w, input logic bv,
		input logic [31:0] bt, input logic h);
		logic        fullNow;
		logic [31:0] tagPc;
		queueEntry_t head;
		fullNow = (modelQ.size() == QueueDepth);
		expValid = (modelQ.size() != 0) && !h;
		if (expValid) begin
			head = modelQ.pop_front();
			expRec = refDecode(head.pc, head.ir);
		end
		// A word reaching a full queue is lost and flags overflow
		if (mPushValid) begin
			if (fullNow) begin
				expOverflow = 1'b1;
			end else begin
				modelQ.push_back(mPushEntry);
			end
		end
		tagPc = bv ? bt : mPc;
		mPushValid = iv;
		if (iv) begin
			mPushEntry.pc = tagPc;
			mPushEntry.ir = w;
			mPc = tagPc + 32'd4;
		end else if (bv) begin
			mPc = bt;
		end
	endtask

	task automatic resetModel();
		modelQ.delete();
		mPushValid = 1'b0;
		mPushEntry = '0;
		mPc = ResetPc;
		expValid = 1'b0;
		expRec = '0;
		expOverflow = 1'b0;
	endtask

	// ========================================================================
	// Stimulus
	// ========================================================================

	function automatic logic chance(input int pct);
		return ($unsigned($random(seed)) % 100) < pct;
	endfunction

	// Random bits under an opcode from the list
	function automatic Instruction randomWord();
		logic [31:0] bits;
		int          idx;
		bits = $random(seed);
		idx = int'($unsigned($random(seed)) % 22);
		bits[6:0] = opTable[idx];
		return bits;
	endfunction

	function automatic logic [31:0] randomTarget();
		logic [31:0] t;
		t = $random(seed);
		t[1:0] = 2'b00;
		return t;
	endfunction

	// Drives the inputs 2 ns after an edge and checks the outputs just after the next edge
	task automatic runCycle(input logic iv, input Instruction w, input logic bv,
		input logic [31:0] bt, input logic h);
		instrValid = iv;
		instrWord = w;
		branchValid = bv;
		branchTarget = bt;
		hold = h;
		@(posedge clk);
		advanceModel(iv, w, bv, bt, h);
		#2;
		checkOutputs();
	endtask

	task automatic randomCycles(input int n, input int ivPct, input int bvPct, input int hPct);
		repeat (n) begin
			runCycle(chance(ivPct), randomWord(), chance(bvPct), randomTarget(), chance(hPct));
		end
	endtask

	// Hold toggles in stretches of 3 to 20 cycles
	task automatic holdStretches(input int n);
		logic h;
		int   left;
		h = 1'b0;
		left = 0;
		repeat (n) begin
			if (left == 0) begin
				h = ~h;
				left = 3 + int'($unsigned($random(seed)) % 18);
			end
			left--;
			runCycle(chance(30), randomWord(), chance(5), randomTarget(), h);
		end
	endtask

	task automatic applyReset();
		instrValid = 1'b0;
		instrWord = '0;
		branchValid = 1'b0;
		branchTarget = '0;
		hold = 1'b0;
		arstN = 1'b0;
		repeat (ResetCycles) @(posedge clk);
		#2;
		arstN = 1'b1;
		resetModel();
		checkOutputs();
	endtask

	// Single word into an empty queue with the edges counted up to the one sampling decValid
	task automatic measureLatency();
		int lat;
		runCycle(1'b1, randomWord(), 1'b0, '0, 1'b0);
		lat = 1;
		while (!decValid && lat < LatencyCycles - 1) begin
			runCycle(1'b0, '0, 1'b0, '0, 1'b0);
			lat++;
		end
		if (!decValid) failRun("No decoded word appeared after a single strobe");
		if (lat != 3) failRun("Decoded word did not follow its strobe by three cycles");
	endtask

	initial begin
		seed = 32'h80b8_1c10;
		errorCount = 0;
		resetModel();
		applyReset();
		measureLatency();
		randomCycles(RandomCycles, 50, 10, 20);
		holdStretches(HoldCycles);

		// Start the fill from an empty queue with overflow still clear
		applyReset();
		// Strobe every cycle with the stage held so words beyond QueueDepth are dropped
		repeat (FillCycles) begin
			runCycle(1'b1, randomWord(), 1'b0, '0, 1'b1);
		end
		checkLevel("overflow", overflow, 1'b1);

		// Overflow must stay set through draining and more traffic
		randomCycles(DrainCycles, 30, 10, 10);
		applyReset();
		randomCycles(TailCycles, 50, 10, 20);

		if (errorCount == 0) begin
			$display("Done: no errors");
			$finish;
		end else begin
			failRun("Checks failed during the run");
		end
	end

endmodule

// ==== compile.f ====
logic/thorDecodePkg.sv
logic/thorFetchSequencer.sv
logic/thorInstrQueue.sv
logic/thorDecodeClass.sv
logic/thorDecodeRvm.sv
logic/thorDecodeStage.sv
logic/thorDecodeTop.sv
dv/thorDecodeTb.sv

// ==== Makefile ====
TOP = thorDecodeTb

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing -sv -f compile.f --top-module $(TOP) -Mdir obj_dir -o simv

run: build
	./obj_dir/simv | tee sim.log
	grep -q "Done: no errors" sim.log

lint:
	verilator --lint-only --timing -sv -f compile.f --top-module $(TOP)

clean:
	rm -rf obj_dir sim.log
